/* logic/amp_spi_pkg.sv */
/*
  shared constants and types for the amplifier gain-control SPI front end:
  channel count, word length, sck divider, word and mask types,
  sequencer state enum and read/write flag enum
*/
`default_nettype none

package amp_spi_pkg;

  // amplifier bank
  localparam int num_channels = 4;
  localparam int addr_w = $clog2(num_channels);

  // SPI word and sck timing
  localparam int word_w = 16;
  localparam int clk_div = 4;
  localparam int div_w = $clog2(clk_div);
  localparam int bit_cnt_w = $clog2(word_w);

  typedef logic [addr_w-1:0] chan_addr_t;
  typedef logic [word_w-1:0] amp_word_t;
  // active low, one bit per amplifier
  typedef logic [num_channels-1:0] cs_mask_t;

  typedef enum logic [1:0] {
    st_idle,
    st_select,
    st_shift,
    st_deselect
  } seq_state_t;

  // value of bit 15 on the wire
  typedef enum logic {
    op_write = 1'b0,
    op_read  = 1'b1
  } spi_op_t;

endpackage

`default_nettype wire

/* logic/spi_ctrl_if.sv */
/*
  control strobes shared by the sequencer, the sck timer,
  the word shifter and the chip-select decoder
*/
`default_nettype none

interface spi_ctrl_if;

  // from the sequencer
  logic load;
  logic run;
  logic sck_en;
  logic select;

  // from the sck timer
  logic half_tick;
  logic fall;
  logic bit_last;

  modport seq (output load, run, sck_en, select, input half_tick, fall, bit_last);

  modport timer (input run, sck_en, output half_tick, fall, bit_last);

  modport shifter (input load, fall, select);

  modport cs (input load, select);

endinterface

`default_nettype wire

/* logic/amp_spi_seq.sv */
/*
  command sequencer: accepts one command on the valid/ready pair and
  walks through select, shift and deselect phases
*/
`default_nettype none

module amp_spi_seq (
  input wire clk,
  input wire reset,
  input wire cmd_valid,
  output logic cmd_ready,
  spi_ctrl_if.seq ctrl
);

  amp_spi_pkg::seq_state_t state;
  logic accept;

  // a command is taken on any edge where both strobes are high
  assign accept = cmd_valid && cmd_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= amp_spi_pkg::st_idle;
      cmd_ready <= 1'b1;
    end else begin
      case (state)
        amp_spi_pkg::st_idle: begin
          if (accept) begin
            state <= amp_spi_pkg::st_select;
            cmd_ready <= 1'b0;
          end
        end
        // chip-select setup, one half period with sck low
        amp_spi_pkg::st_select: begin
          if (ctrl.half_tick) begin
            state <= amp_spi_pkg::st_shift;
          end
        end
        // leave on the falling edge that ends the last bit
        amp_spi_pkg::st_shift: begin
          if (ctrl.fall && ctrl.bit_last) begin
            state <= amp_spi_pkg::st_deselect;
          end
        end
        // chip-select hold, one half period
        amp_spi_pkg::st_deselect: begin
          if (ctrl.half_tick) begin
            state <= amp_spi_pkg::st_idle;
            cmd_ready <= 1'b1;
          end
        end
        default: begin
          state <= amp_spi_pkg::st_idle;
          cmd_ready <= 1'b1;
        end
      endcase
    end
  end

  // load fires in the accept cycle so the data modules capture the
  // command on the same edge
  assign ctrl.load = accept;
  assign ctrl.run = (state != amp_spi_pkg::st_idle);
  assign ctrl.sck_en = (state == amp_spi_pkg::st_shift);
  assign ctrl.select = (state == amp_spi_pkg::st_select) ||
                       (state == amp_spi_pkg::st_shift);

  // ready and the state register must agree
  a_ready_only_idle: assert property (
    @(posedge clk) disable iff (reset)
    cmd_ready |-> (state == amp_spi_pkg::st_idle)
  ) else $error("cmd_ready high in state %s", state.name());

endmodule

`default_nettype wire

/* logic/sck_timer.sv */
/*
  sck generator: half-period divider, sck toggle register,
  falling-edge strobe and bit counter
*/
`default_nettype none

module sck_timer (
  input wire clk,
  input wire reset,
  output logic sck,
  spi_ctrl_if.timer ctrl
);

  logic [amp_spi_pkg::div_w-1:0] div_cnt;
  logic [amp_spi_pkg::bit_cnt_w-1:0] bit_cnt;

  // divider restarts every time the sequencer leaves idle
  always_ff @(posedge clk) begin
    if (reset || !ctrl.run) begin
      div_cnt <= '0;
    end else if (ctrl.half_tick) begin
      div_cnt <= '0;
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  assign ctrl.half_tick = ctrl.run &&
                          (div_cnt == amp_spi_pkg::div_w'(amp_spi_pkg::clk_div - 1));

  always_ff @(posedge clk) begin
    if (reset) begin
      sck <= 1'b0;
    end else if (ctrl.half_tick && ctrl.sck_en) begin
      sck <= ~sck;
    end
  end

  // high in the cycle whose closing edge brings sck low
  assign ctrl.fall = ctrl.half_tick && ctrl.sck_en && sck;

  // counts completed bits, so it names the bit now on sdi
  always_ff @(posedge clk) begin
    if (reset || !ctrl.run) begin
      bit_cnt <= '0;
    end else if (ctrl.fall) begin
      bit_cnt <= bit_cnt + 1'b1;
    end
  end

  assign ctrl.bit_last =
    (bit_cnt == amp_spi_pkg::bit_cnt_w'(amp_spi_pkg::word_w - 1));

  // sck parks low once the shift phase is over
  a_sck_idle_low: assert property (
    @(posedge clk) disable iff (reset)
    (!ctrl.sck_en) [*amp_spi_pkg::clk_div] |-> !sck
  ) else $error("sck high with shifting disabled");

endmodule

`default_nettype wire

/* logic/word_shifter.sv */
/*
  output shift register: loads the command word with the write flag
  forced into bit 15 and drives sdi MSB first
*/
`default_nettype none

module word_shifter (
  input wire clk,
  input wire reset,
  input wire amp_spi_pkg::amp_word_t cmd_word,
  output logic sdi,
  spi_ctrl_if.shifter ctrl
);

  // bits below the read/write flag, next bit at the top
  logic [amp_spi_pkg::word_w-2:0] rest;

  always_ff @(posedge clk) begin
    if (ctrl.load) begin
      rest <= cmd_word[amp_spi_pkg::word_w-2:0];
    end else if (ctrl.fall) begin
      rest <= {rest[amp_spi_pkg::word_w-3:0], 1'b0};
    end
  end

  // sdi moves on the edge that drops sck, device samples on the rise
  always_ff @(posedge clk) begin
    if (reset) begin
      sdi <= 1'b0;
    end else if (ctrl.load) begin
      sdi <= logic'(amp_spi_pkg::op_write);
    end else if (ctrl.fall) begin
      sdi <= rest[amp_spi_pkg::word_w-2];
    end else if (!ctrl.select) begin
      sdi <= 1'b0;
    end
  end

  // a new word must never overwrite one still on the wire
  a_load_when_free: assert property (
    @(posedge clk) disable iff (reset)
    ctrl.load |-> !ctrl.select
  ) else $error("word loaded during an active transfer");

endmodule

`default_nettype wire

/* logic/cs_decoder.sv */
/*
  chip-select decoder: address latch and one-hot active-low
  chip-select vector
*/
`default_nettype none

module cs_decoder (
  input wire clk,
  input wire reset,
  input wire amp_spi_pkg::chan_addr_t cmd_addr,
  output amp_spi_pkg::cs_mask_t cs_n,
  spi_ctrl_if.cs ctrl
);

  amp_spi_pkg::chan_addr_t addr_q;

  always_ff @(posedge clk) begin
    if (ctrl.load) begin
      addr_q <= cmd_addr;
    end
  end

  // addr_q is frozen while select is high, so only one cs_n bit
  // ever changes on a select edge
  always_comb begin
    cs_n = '1;
    if (ctrl.select) begin
      cs_n[addr_q] = 1'b0;
    end
  end

  // the selected amplifier stays the same for the whole transfer
  a_cs_stable: assert property (
    @(posedge clk) disable iff (reset)
    (ctrl.select && $past(ctrl.select)) |-> $stable(cs_n)
  ) else $error("chip select changed during an active transfer: %b", cs_n);

endmodule

`default_nettype wire

/* logic/amp_spi_top.sv */
/*
  top level of the gain-control SPI front end: command handshake in,
  sck, sdi and per-amplifier chip selects out
*/
`default_nettype none

module amp_spi_top (
  input wire clk,
  input wire reset,
  input wire cmd_valid,
  input wire amp_spi_pkg::chan_addr_t cmd_addr,
  input wire amp_spi_pkg::amp_word_t cmd_word,
  output logic cmd_ready,
  output logic sck,
  output logic sdi,
  output amp_spi_pkg::cs_mask_t cs_n
);

  spi_ctrl_if ctrl ();

  // phase control and handshake
  amp_spi_seq i_amp_spi_seq (
    .clk       (clk),
    .reset     (reset),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .ctrl      (ctrl.seq)
  );

  // sck and bit timing
  sck_timer i_sck_timer (
    .clk   (clk),
    .reset (reset),
    .sck   (sck),
    .ctrl  (ctrl.timer)
  );

  word_shifter i_word_shifter (
    .clk      (clk),
    .reset    (reset),
    .cmd_word (cmd_word),
    .sdi      (sdi),
    .ctrl     (ctrl.shifter)
  );

  cs_decoder i_cs_decoder (
    .clk      (clk),
    .reset    (reset),
    .cmd_addr (cmd_addr),
    .cs_n     (cs_n),
    .ctrl     (ctrl.cs)
  );

endmodule

`default_nettype wire

/* tb/amp_spi_tb.sv */
/*
  directed testbench for the gain-control SPI front end: clock and reset,
  LFSR stimulus, bus monitor, compare tasks and one task per test
*/
`default_nettype none

module amp_spi_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int accept_limit = 400;
  localparam int ready_limit = 400;
  localparam int latency = 34 * amp_spi_pkg::clk_div + 1;

  logic clk;
  logic reset;
  logic cmd_valid;
  amp_spi_pkg::chan_addr_t cmd_addr;
  amp_spi_pkg::amp_word_t cmd_word;
  logic cmd_ready;
  logic sck;
  logic sdi;
  amp_spi_pkg::cs_mask_t cs_n;

  int err_value;
  int err_other;
  logic [31:0] lfsr_state;

  // sent and seen words, in bus order
  amp_spi_pkg::amp_word_t exp_word_q[$];
  amp_spi_pkg::cs_mask_t exp_cs_q[$];
  amp_spi_pkg::amp_word_t cap_word_q[$];
  amp_spi_pkg::cs_mask_t cap_cs_q[$];

  // monitor state
  logic sck_q;
  logic in_word;
  int bit_n;
  amp_spi_pkg::amp_word_t shift_w;
  amp_spi_pkg::cs_mask_t cs_word;

  amp_spi_top i_amp_spi_top (
    .clk       (clk),
    .reset     (reset),
    .cmd_valid (cmd_valid),
    .cmd_addr  (cmd_addr),
    .cmd_word  (cmd_word),
    .cmd_ready (cmd_ready),
    .sck       (sck),
    .sdi       (sdi),
    .cs_n      (cs_n)
  );

  always #10 clk = ~clk;

  task automatic end_run();
    $display("errors: %0d value mismatches, %0d other failures", err_value, err_other);
    if (err_value + err_other == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  endtask

  task automatic report_timeout(input string what);
    err_other++;
    $display("%0t: timeout while %s", $time, what);
    end_run();
  endtask

  task automatic check_word(input string name, input amp_spi_pkg::amp_word_t got,
                            input amp_spi_pkg::amp_word_t exp);
    if (got !== exp) begin
      err_value++;
      $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_cs(input string name, input amp_spi_pkg::cs_mask_t got,
                          input amp_spi_pkg::cs_mask_t exp);
    if (got !== exp) begin
      err_value++;
      $display("ERR %0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      err_value++;
      $display("ERR %0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      err_value++;
      $display("ERR %0t %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  // 32-bit Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
  endtask

  function automatic amp_spi_pkg::cs_mask_t cs_for(input amp_spi_pkg::chan_addr_t a);
    amp_spi_pkg::cs_mask_t m;
    m = '1;
    m[a] = 1'b0;
    return m;
  endfunction

  // bus monitor, values read at posedge are those of the closing cycle
  always @(posedge clk) begin
    if (reset) begin
      sck_q = 1'b0;
      in_word = 1'b0;
      bit_n = 0;
    end else begin
      if ($countones(~cs_n) > 1) begin
        err_other++;
        $display("%0t: more than one chip select active, cs_n is %b", $time, cs_n);
      end
      if (cs_n != '1) begin
        if (!in_word) begin
          in_word = 1'b1;
          cs_word = cs_n;
          bit_n = 0;
        end else if (cs_n != cs_word) begin
          err_other++;
          $display("%0t: chip select changed in the middle of a word", $time);
        end
        if (sck && !sck_q) begin
          shift_w = {shift_w[amp_spi_pkg::word_w-2:0], sdi};
          bit_n++;
        end
      end else begin
        check_bit("sck", sck, 1'b0);
        if (in_word) begin
          check_count("sck rising edges per word", bit_n, amp_spi_pkg::word_w);
          cap_word_q.push_back(shift_w);
          cap_cs_q.push_back(cs_word);
          in_word = 1'b0;
        end
      end
      sck_q = sck;
    end
  end

  // all stimulus tasks are entered right after a rising clk edge
  task automatic put_cmd(input amp_spi_pkg::chan_addr_t a, input amp_spi_pkg::amp_word_t w);
    cmd_valid <= 1'b1;
    cmd_addr <= a;
    cmd_word <= w;
  endtask

  // returns on the accept edge and records what was taken
  task automatic wait_accept();
    amp_spi_pkg::amp_word_t w;
    int n;
    n = 0;
    @(posedge clk);
    while (!cmd_ready) begin
      n++;
      if (n > accept_limit) begin
        report_timeout("waiting for a command to be accepted");
      end
      @(posedge clk);
    end
    w = cmd_word;
    w[amp_spi_pkg::word_w-1] = logic'(amp_spi_pkg::op_write);
    exp_word_q.push_back(w);
    exp_cs_q.push_back(cs_for(cmd_addr));
  endtask

  // counts edges from the accept edge until ready is seen again
  task automatic wait_ready(output int cycles);
    amp_spi_pkg::cs_mask_t cs_last;
    cycles = 0;
    cs_last = '1;
    do begin
      @(posedge clk);
      cycles++;
      if (cycles > ready_limit) begin
        report_timeout("waiting for cmd_ready to return");
      end
      // cs_n in the last cycle with ready still low
      if (!cmd_ready) begin
        cs_last = cs_n;
      end
    end while (!cmd_ready);
    check_cs("cs_n before ready", cs_last, '1);
    check_cs("cs_n", cs_n, '1);
  endtask

  task automatic compare_results(input string test);
    int n;
    if (cap_word_q.size() != exp_word_q.size()) begin
      err_other++;
      $display("%0t: %s saw %0d words on the bus but %0d were accepted", $time, test,
               cap_word_q.size(), exp_word_q.size());
    end
    n = (cap_word_q.size() < exp_word_q.size()) ? cap_word_q.size() : exp_word_q.size();
    for (int i = 0; i < n; i++) begin
      check_word("sdi word", cap_word_q[i], exp_word_q[i]);
      check_cs("cs_n", cap_cs_q[i], exp_cs_q[i]);
    end
    cap_word_q.delete();
    cap_cs_q.delete();
    exp_word_q.delete();
    exp_cs_q.delete();
  endtask

  task automatic run_one(input amp_spi_pkg::chan_addr_t a, input amp_spi_pkg::amp_word_t w);
    int cycles;
    put_cmd(a, w);
    wait_accept();
    cmd_valid <= 1'b0;
    wait_ready(cycles);
    check_count("accept to ready cycles", cycles, latency);
  endtask

  task automatic reset_values();
    check_bit("cmd_ready", cmd_ready, 1'b1);
    check_cs("cs_n", cs_n, '1);
    check_bit("sck", sck, 1'b0);
    check_bit("sdi", sdi, 1'b0);
  endtask

  // bit 15 set here must go out as a write
  task automatic single_write();
    run_one(2'd2, 16'ha5c3);
    compare_results("single write");
  endtask

  task automatic channel_select();
    logic [31:0] r;
    for (int a = 0; a < amp_spi_pkg::num_channels; a++) begin
      draw_bits(amp_spi_pkg::word_w, r);
      run_one(amp_spi_pkg::chan_addr_t'(a), r[15:0]);
    end
    compare_results("channel select");
  endtask

  task automatic back_pressure();
    int cycles;
    put_cmd(2'd1, 16'h1234);
    wait_accept();
    // valid stays high, inputs move while the first word is on the wire
    put_cmd(2'd0, 16'hbeef);
    repeat (20) @(posedge clk);
    put_cmd(2'd3, 16'h8a5f);
    wait_accept();
    cmd_valid <= 1'b0;
    wait_ready(cycles);
    check_count("accept to ready cycles", cycles, latency);
    compare_results("back-pressure");
  endtask

  task automatic random_stream();
    logic [31:0] a;
    logic [31:0] w;
    logic [31:0] gap;
    int cycles;
    for (int i = 0; i < 50; i++) begin
      draw_bits(amp_spi_pkg::addr_w, a);
      draw_bits(amp_spi_pkg::word_w, w);
      // long enough to sometimes outlast a transfer
      draw_bits(8, gap);
      put_cmd(a[amp_spi_pkg::addr_w-1:0], w[15:0]);
      wait_accept();
      if (gap != 0) begin
        cmd_valid <= 1'b0;
        repeat (gap) @(posedge clk);
      end
    end
    cmd_valid <= 1'b0;
    wait_ready(cycles);
    compare_results("random stream");
  endtask

  // overall limit on top of the per-wait limits
  initial begin
    #1_000_000;
    report_timeout("running, the simulation limit was reached");
  end

  initial begin
    clk = 1'b0;
    reset = 1'b1;
    cmd_valid = 1'b0;
    cmd_addr = '0;
    cmd_word = '0;
    lfsr_state = 32'hdcd;
    err_value = 0;
    err_other = 0;
    repeat (16) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);
    reset_values();
    single_write();
    channel_select();
    back_pressure();
    random_stream();
    repeat (4) @(posedge clk);
    end_run();
  end

endmodule

`default_nettype wire

/* list.f */
logic/amp_spi_pkg.sv
logic/spi_ctrl_if.sv
logic/amp_spi_seq.sv
logic/sck_timer.sv
logic/word_shifter.sv
logic/cs_decoder.sv
logic/amp_spi_top.sv
tb/amp_spi_tb.sv

/* Bender.yml */
package:
  name: amp_spi

sources:
  - logic/amp_spi_pkg.sv
  - logic/spi_ctrl_if.sv
  - logic/amp_spi_seq.sv
  - logic/sck_timer.sv
  - logic/word_shifter.sv
  - logic/cs_decoder.sv
  - logic/amp_spi_top.sv
  - target: test
    files:
      - tb/amp_spi_tb.sv
